//--- irq_pkg.sv
`default_nettype none

package irq_pkg;

    // Source counts. Source 1 is the timer, 2 to 8 are external lines.
    localparam int IRQ_CNT     = 8;
    localparam int EXT_IRQ_CNT = 7;

    // Clock cycles per time increment.
    localparam int TICK_DIV = 4;
    localparam int TICK_W   = $clog2(TICK_DIV);

    localparam int ADDR_W  = 24;
    localparam int DATA_W  = 32;
    localparam int STRB_W  = 4;
    localparam int ID_W    = 4;
    localparam int MTIME_W = 64;

    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [STRB_W-1:0]    strb_t;
    typedef logic [IRQ_CNT:1]     irq_vec_t;   // Indexed by source id.
    typedef logic [EXT_IRQ_CNT-1:0] ext_irq_t;
    typedef logic [ID_W-1:0]      irq_id_t;    // 0 means no interrupt.
    typedef logic [MTIME_W-1:0]   mtime_t;
    typedef logic [TICK_W-1:0]    tick_cnt_t;

    // Region bases, selected by address bits 23 to 16.
    localparam addr_t PLIC_BASE  = 24'h000000;
    localparam addr_t TIMER_BASE = 24'h010000;
    localparam addr_t OFS_MASK   = 24'h00ffff;

    // Interrupt controller register offsets.
    localparam addr_t PLIC_CLAIM_OFS = 24'h000000;
    localparam addr_t PLIC_PEND_OFS  = 24'h000004;
    localparam addr_t PLIC_EN_OFS    = 24'h000008;

    // Timer register offsets.
    localparam addr_t MTIME_LO_OFS    = 24'h000000;
    localparam addr_t MTIME_HI_OFS    = 24'h000004;
    localparam addr_t MTIMECMP_LO_OFS = 24'h000008;
    localparam addr_t MTIMECMP_HI_OFS = 24'h00000c;

    // Simple memory-mapped bus request.
    typedef struct packed {
        logic  en;
        strb_t we;      // Nonzero means write.
        addr_t addr;
        data_t wdata;
    } bus_req_t;

endpackage

`default_nettype wire

//--- irq_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none

module irq_subsys_top
    import irq_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  bus_req_t bus_req_i,
    output data_t    rdata_o,

    input  ext_irq_t ext_irq_i,
    input  logic     iack_i,
    output ext_irq_t ext_iack_o,
    output logic     irq_o
);

    bus_req_t plic_req;
    bus_req_t timer_req;
    data_t    plic_rdata;
    data_t    timer_rdata;
    logic     timer_irq;
    irq_vec_t irq_vec;
    irq_vec_t iack_vec;

    // Timer on source 1, external lines on 2 to 8.
    assign irq_vec    = {ext_irq_i, timer_irq};
    assign ext_iack_o = iack_vec[IRQ_CNT:2];   // Timer bit is not forwarded.

    periph_bus u_periph_bus (
        .clk           (clk),
        .reset         (reset),
        .req_i         (bus_req_i),
        .plic_req_o    (plic_req),
        .timer_req_o   (timer_req),
        .plic_rdata_i  (plic_rdata),
        .timer_rdata_i (timer_rdata),
        .rdata_o       (rdata_o)
    );

    rtc_timer u_rtc_timer (
        .clk         (clk),
        .reset       (reset),
        .req_i       (timer_req),
        .rdata_o     (timer_rdata),
        .timer_irq_o (timer_irq)
    );

    plic u_plic (
        .clk     (clk),
        .reset   (reset),
        .req_i   (plic_req),
        .rdata_o (plic_rdata),
        .irq_i   (irq_vec),
        .iack_i  (iack_i),
        .iack_o  (iack_vec),
        .irq_o   (irq_o)
    );

endmodule

`default_nettype wire

//--- periph_bus.sv
`timescale 1ns/1ns
`default_nettype none

module periph_bus
    import irq_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  bus_req_t req_i,

    output bus_req_t plic_req_o,
    output bus_req_t timer_req_o,

    input  data_t    plic_rdata_i,
    input  data_t    timer_rdata_i,
    output data_t    rdata_o
);

    logic hit_plic;
    logic hit_timer;
    logic rd_req;
    logic sel_plic_q;       // Region of the last read.
    logic sel_timer_q;

    assign hit_plic  = (req_i.addr[23:16] == PLIC_BASE[23:16]);
    assign hit_timer = (req_i.addr[23:16] == TIMER_BASE[23:16]);
    assign rd_req    = req_i.en && (req_i.we == '0);

    // Same request to both, each enable gated by its region.
    always_comb begin
        plic_req_o       = req_i;
        plic_req_o.en    = req_i.en && hit_plic;
        plic_req_o.addr  = req_i.addr & OFS_MASK;

        timer_req_o      = req_i;
        timer_req_o.en   = req_i.en && hit_timer;
        timer_req_o.addr = req_i.addr & OFS_MASK;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sel_plic_q  <= 1'b0;
            sel_timer_q <= 1'b0;
        end else if (rd_req) begin
            sel_plic_q  <= hit_plic;
            sel_timer_q <= hit_timer;
        end
    end

    // Unmapped region reads zero.
    assign rdata_o = sel_plic_q  ? plic_rdata_i  :
                     sel_timer_q ? timer_rdata_i : '0;

    assert property (@(posedge clk) disable iff (reset)
        !(plic_req_o.en && timer_req_o.en))
        else $error("periph_bus: both peripherals enabled");

endmodule

`default_nettype wire

//--- plic.sv
`timescale 1ns/1ns
`default_nettype none

module plic
    import irq_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  bus_req_t req_i,
    output data_t    rdata_o,

    input  irq_vec_t irq_i,
    input  logic     iack_i,

    output irq_vec_t iack_o,
    output logic     irq_o
);

    irq_vec_t ip;           // Pending, sampled from the sources.
    irq_vec_t ie;           // Enable register.
    irq_vec_t interrupt;
    irq_id_t  id_win;       // Lowest enabled pending id.
    irq_id_t  claim_id;

    logic bus_wr;
    logic bus_rd;

    assign bus_wr = req_i.en && (req_i.we != '0);
    assign bus_rd = req_i.en && (req_i.we == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            ip <= '0;
        end else begin
            ip <= irq_i;
        end
    end

    assign interrupt = ip & ie;

    // Scan from the top so the lowest id is the last one to win.
    always_comb begin
        id_win = '0;
        for (int i = IRQ_CNT; i >= 1; i--) begin
            if (interrupt[i]) begin
                id_win = irq_id_t'(i);
            end
        end
    end

    always_comb begin
        iack_o = '0;
        for (int i = 1; i <= IRQ_CNT; i++) begin
            iack_o[i] = iack_i && (id_win == irq_id_t'(i));
        end
    end

    assign irq_o = (|interrupt) && !iack_i;   // Held low during acknowledge.

    always_ff @(posedge clk) begin
        if (reset) begin
            claim_id <= '0;
        end else if (iack_i) begin
            claim_id <= id_win;
        end
    end

    // Enable register. Any nonzero strobe writes the whole word.
    always_ff @(posedge clk) begin
        if (reset) begin
            ie <= '0;
        end else if (bus_wr && (req_i.addr == PLIC_EN_OFS)) begin
            ie <= req_i.wdata[IRQ_CNT:1];
        end
    end

    // Registered read data, held until the next read.
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata_o <= '0;
        end else if (bus_rd) begin
            case (req_i.addr)
                PLIC_CLAIM_OFS: rdata_o <= {{(DATA_W-ID_W){1'b0}}, claim_id};
                PLIC_PEND_OFS:  rdata_o <= {{(DATA_W-1-IRQ_CNT){1'b0}}, ip, 1'b0};
                PLIC_EN_OFS:    rdata_o <= {{(DATA_W-1-IRQ_CNT){1'b0}}, ie, 1'b0};
                default:        rdata_o <= '0;
            endcase
        end
    end

    // The acknowledge goes to one source at most, and only when the core asks.
    assert property (@(posedge clk) disable iff (reset)
        $onehot0(iack_o) && (iack_i || (iack_o == '0)))
        else $error("plic: bad acknowledge vector %b", iack_o);

endmodule

`default_nettype wire

//--- rtc_timer.sv
`timescale 1ns/1ns
`default_nettype none

module rtc_timer
    import irq_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  bus_req_t req_i,
    output data_t    rdata_o,

    output logic     timer_irq_o
);

    tick_cnt_t tick_cnt;
    logic      tick;
    mtime_t    mtime;
    mtime_t    mtimecmp;

    logic bus_wr;
    logic bus_rd;

    assign bus_wr = req_i.en && (req_i.we != '0);
    assign bus_rd = req_i.en && (req_i.we == '0);

    // Prescaler. The last count of each period advances the time value.
    assign tick = (tick_cnt == tick_cnt_t'(TICK_DIV - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mtime <= '0;
        end else if (tick) begin
            mtime <= mtime + 1'b1;
        end
    end

    // Compare value, written by word halves.
    always_ff @(posedge clk) begin
        if (reset) begin
            mtimecmp <= '1;        // Never reached after reset.
        end else if (bus_wr) begin
            case (req_i.addr)
                MTIMECMP_LO_OFS: mtimecmp[31:0]  <= req_i.wdata;
                MTIMECMP_HI_OFS: mtimecmp[63:32] <= req_i.wdata;
                default:         ;
            endcase
        end
    end

    // Level interrupt, cleared by moving the compare value ahead.
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_irq_o <= 1'b0;
        end else begin
            timer_irq_o <= (mtime >= mtimecmp);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rdata_o <= '0;
        end else if (bus_rd) begin
            case (req_i.addr)
                MTIME_LO_OFS:    rdata_o <= mtime[31:0];
                MTIME_HI_OFS:    rdata_o <= mtime[63:32];
                MTIMECMP_LO_OFS: rdata_o <= mtimecmp[31:0];
                MTIMECMP_HI_OFS: rdata_o <= mtimecmp[63:32];
                default:         rdata_o <= '0;
            endcase
        end
    end

    // Interrupt only follows a cycle in which the time had reached the compare.
    assert property (@(posedge clk) disable iff (reset)
        timer_irq_o |-> $past(mtime >= mtimecmp))
        else $error("rtc_timer: interrupt without a compare match");

endmodule

`default_nettype wire

//--- src.f
irq_pkg.sv
plic.sv
rtc_timer.sv
periph_bus.sv
irq_subsys_top.sv
tb_irq_subsys.sv

//--- tb_irq_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_irq_subsys
    import irq_pkg::*;
();

    localparam logic [31:0] LFSR_SEED = 32'h46cf314e;
    localparam int IRQ_TIMEOUT  = 100;     // Cycles allowed for the timer interrupt.
    localparam int DROP_TIMEOUT = 20;
    localparam int LOOP_CNT     = 16;
    localparam int TIME_GAP     = 40;

    // Expected controller response for one set of pending and enable bits.
    typedef struct packed {
        irq_id_t  id;
        logic     irq;
        irq_vec_t ack;
    } expect_t;

    logic     clk;
    logic     reset;
    bus_req_t bus_req;
    data_t    rdata;
    ext_irq_t ext_irq;
    logic     iack;
    ext_irq_t ext_iack;
    logic     irq;

    logic [31:0] lfsr_state;
    logic        monitor_on;   // Set while model_pend and model_en describe the DUT.
    irq_vec_t    model_pend;
    irq_vec_t    model_en;

    irq_subsys_top u_irq_subsys_top (
        .clk        (clk),
        .reset      (reset),
        .bus_req_i  (bus_req),
        .rdata_o    (rdata),
        .ext_irq_i  (ext_irq),
        .iack_i     (iack),
        .ext_iack_o (ext_iack),
        .irq_o      (irq)
    );

    always #5 clk = ~clk;

    // Galois LFSR, polynomial x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(logic [31:0] state);
        logic lsb;
        lsb = state[0];
        state = state >> 1;
        if (lsb) begin
            state = state ^ 32'h80200003;
        end
        return state;
    endfunction

    function automatic logic [31:0] draw_bits(int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value[i] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
        return value;
    endfunction

    // Lowest enabled pending source wins. Id 0 means none.
    function automatic expect_t predict(irq_vec_t pend, irq_vec_t en, logic ack_req);
        expect_t  r;
        irq_vec_t active;
        logic     found;
        r = '0;
        found = 1'b0;
        active = pend & en;
        for (int i = 1; i <= IRQ_CNT; i++) begin
            if (active[i] && !found) begin
                found = 1'b1;
                r.id = irq_id_t'(i);
                r.ack[i] = ack_req;
            end
        end
        r.irq = (active != '0) && !ack_req;   // Masked during acknowledge.
        return r;
    endfunction

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_data(data_t got, data_t want, string what);
        if (got !== want) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_id(irq_id_t got, irq_id_t want, string what);
        if (got !== want) begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_ack(ext_irq_t got, ext_irq_t want, string what);
        if (got !== want) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_level(logic got, logic want, string what);
        if (got !== want) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, want);
            stop_on_error();
        end
    endtask

    // Any nonzero strobe writes the whole word.
    task automatic bus_write(addr_t addr, data_t data);
        bus_req_t req;
        req.en = 1'b1;
        req.we = strb_t'(draw_bits(STRB_W));
        if (req.we == '0) begin
            req.we = 4'b0001;
        end
        req.addr = addr;
        req.wdata = data;
        @(posedge clk);
        bus_req <= req;
        @(posedge clk);
        bus_req <= '0;
    endtask

    task automatic bus_read(addr_t addr, output data_t data);
        bus_req_t req;
        req = '0;
        req.en = 1'b1;
        req.addr = addr;
        @(posedge clk);
        bus_req <= req;
        @(posedge clk);
        bus_req <= '0;
        @(negedge clk);
        data = rdata;           // Registered one cycle after the request.
    endtask

    task automatic pulse_iack(ext_irq_t want_ack);
        @(posedge clk);
        iack <= 1'b1;
        @(negedge clk);
        check_ack(ext_iack, want_ack, "ext_iack_o during acknowledge");
        check_level(irq, 1'b0, "irq_o during acknowledge");
        @(posedge clk);
        iack <= 1'b0;
    endtask

    task automatic wait_irq(logic level, int limit, string what);
        int n;
        n = 0;
        @(negedge clk);
        while ((irq !== level) && (n < limit)) begin
            @(negedge clk);
            n++;
        end
        if (irq !== level) begin
            $display("Timeout: %s", what);
            stop_on_error();
        end
    endtask

    // Compares irq_o and the acknowledge with the model on every falling edge.
    always @(negedge clk) begin
        expect_t want;
        if (monitor_on) begin
            want = predict(model_pend, model_en, iack);
            check_level(irq, want.irq, "irq_o");
            check_ack(ext_iack, want.ack[IRQ_CNT:2], "ext_iack_o");
        end
    end

    initial begin
        data_t    rd;
        data_t    wval;
        data_t    t0;
        data_t    t1;
        data_t    delta;
        data_t    want_delta;
        ext_irq_t lines;
        expect_t  want;

        clk = 1'b0;
        reset = 1'b1;
        bus_req = '0;
        ext_irq = '0;
        iack = 1'b0;
        lfsr_state = LFSR_SEED;
        monitor_on = 1'b0;
        model_pend = '0;
        model_en = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // Reset values.
        @(negedge clk);
        check_level(irq, 1'b0, "irq_o after reset");
        check_ack(ext_iack, '0, "ext_iack_o after reset");
        bus_read(PLIC_BASE + PLIC_CLAIM_OFS, rd);
        check_id(irq_id_t'(rd), '0, "claim after reset");
        bus_read(PLIC_BASE + PLIC_PEND_OFS, rd);
        check_data(rd, '0, "pending after reset");
        bus_read(PLIC_BASE + PLIC_EN_OFS, rd);
        check_data(rd, '0, "enable after reset");
        bus_read(TIMER_BASE + MTIMECMP_LO_OFS, rd);
        check_data(rd, '1, "compare low after reset");
        bus_read(TIMER_BASE + MTIMECMP_HI_OFS, rd);
        check_data(rd, '1, "compare high after reset");

        // Enable layout, then writes and reads outside the map.
        bus_write(PLIC_BASE + PLIC_EN_OFS, '1);
        bus_read(PLIC_BASE + PLIC_EN_OFS, rd);
        check_data(rd, data_t'({irq_vec_t'('1), 1'b0}), "enable all ones");
        wval = draw_bits(DATA_W);
        bus_write(PLIC_BASE + PLIC_EN_OFS, wval);
        model_en = wval[IRQ_CNT:1];
        bus_write(PLIC_BASE + 24'h000010, draw_bits(DATA_W));
        bus_write(PLIC_BASE + PLIC_CLAIM_OFS, draw_bits(DATA_W));
        bus_write(24'h020000 + PLIC_EN_OFS, draw_bits(DATA_W));
        bus_read(PLIC_BASE + PLIC_EN_OFS, rd);
        check_data(rd, data_t'({model_en, 1'b0}), "enable after unmapped writes");
        bus_read(PLIC_BASE + 24'h000010, rd);
        check_data(rd, '0, "unmapped controller offset");
        bus_read(TIMER_BASE + 24'h000010, rd);
        check_data(rd, '0, "unmapped timer offset");
        bus_read(24'h020000 + PLIC_EN_OFS, rd);
        check_data(rd, '0, "unmapped region");

        // Random lines and enables, each followed by a claim.
        for (int k = 0; k < LOOP_CNT; k++) begin
            monitor_on = 1'b0;
            lines = ext_irq_t'(draw_bits(EXT_IRQ_CNT));
            wval = draw_bits(DATA_W);
            if (k % 4 == 3) begin
                wval = '0;
            end
            @(posedge clk);
            ext_irq <= lines;
            bus_write(PLIC_BASE + PLIC_EN_OFS, wval);
            model_pend = {lines, 1'b0};     // Timer stays quiet with compare at all ones.
            model_en = wval[IRQ_CNT:1];
            monitor_on = 1'b1;
            bus_read(PLIC_BASE + PLIC_PEND_OFS, rd);
            check_data(rd, data_t'({model_pend, 1'b0}), "pending");
            bus_read(PLIC_BASE + PLIC_EN_OFS, rd);
            check_data(rd, data_t'({model_en, 1'b0}), "enable");
            want = predict(model_pend, model_en, 1'b1);
            pulse_iack(want.ack[IRQ_CNT:2]);
            bus_read(PLIC_BASE + PLIC_CLAIM_OFS, rd);
            check_id(irq_id_t'(rd), want.id, "claimed id");
        end
        monitor_on = 1'b0;

        // The two read requests are sampled TIME_GAP + 2 edges apart.
        bus_read(TIMER_BASE + MTIME_LO_OFS, t0);
        repeat (TIME_GAP) @(posedge clk);
        bus_read(TIMER_BASE + MTIME_LO_OFS, t1);
        delta = t1 - t0;
        want_delta = (TIME_GAP + 2) / TICK_DIV;
        if ((delta > want_delta + 1) || (delta + 1 < want_delta)) begin
            check_data(delta, want_delta, "time increase");
        end

        // Timer interrupt with only source 1 enabled.
        @(posedge clk);
        ext_irq <= ext_irq_t'(draw_bits(EXT_IRQ_CNT));
        bus_write(PLIC_BASE + PLIC_EN_OFS, data_t'({irq_vec_t'(1), 1'b0}));
        bus_read(TIMER_BASE + MTIME_LO_OFS, t0);
        bus_write(TIMER_BASE + MTIMECMP_LO_OFS, t0 + 6);
        bus_write(TIMER_BASE + MTIMECMP_HI_OFS, '0);
        wait_irq(1'b1, IRQ_TIMEOUT, "the timer interrupt never raised irq_o");
        pulse_iack('0);
        bus_read(PLIC_BASE + PLIC_CLAIM_OFS, rd);
        check_id(irq_id_t'(rd), irq_id_t'(1), "timer claim");
        bus_write(TIMER_BASE + MTIMECMP_LO_OFS, '1);
        bus_write(TIMER_BASE + MTIMECMP_HI_OFS, '1);
        wait_irq(1'b0, DROP_TIMEOUT, "irq_o stayed high after the compare was set to all ones");

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
